// ==== Makefile ====
# Verilator build and run of the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= csr_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_FLAGS ?= +verilator+error+limit+100

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_FLAGS) | tee $(LOG)
	grep -q "^All tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== csr_unit.f ====
verilog/csr_pkg.sv
verilog/csr_req_queue.sv
verilog/csr_access.sv
verilog/csr_trap_regs.sv
verilog/csr_perf_counters.sv
verilog/csr_unit.sv
tb/tb_clock.sv
tb/csr_unit_chk.sv
tb/csr_unit_tb.sv

// ==== tb/csr_unit_chk.sv ====
// Bound checker for credit return, response timing and queue fill level
module csr_unit_chk #(
  parameter int QUEUE_DEPTH = 2,
  parameter int CNT_W       = $clog2(QUEUE_DEPTH + 1)
) (
  input logic             clk,
  input logic             rst_n,
  input logic             credit_i,
  input logic             rsp_valid_i,
  input logic [CNT_W-1:0] queue_count_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;  // Read by the testbench at the end

  // Quiet while reset is held
  a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (!credit_i && !rsp_valid_i))
    else begin $error("credit or response pulse during reset"); fail_count++; end

  // Credit and response are both registered off the same pop
  a_credit_is_rsp: assert property (@(posedge clk) disable iff (!rst_n)
                                    credit_i == rsp_valid_i)
    else begin $error("credit and response pulses out of step"); fail_count++; end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
                                  queue_count_i <= CNT_W'(QUEUE_DEPTH))
    else begin $error("request queue over its depth"); fail_count++; end

endmodule

bind csr_unit csr_unit_chk #(
  .QUEUE_DEPTH (QUEUE_DEPTH)
) u_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .credit_i      (credit_o),
  .rsp_valid_i   (rsp_valid_o),
  .queue_count_i (u_queue.count_q)
);

// ==== tb/csr_unit_tb.sv ====
// Directed testbench for the CSR unit covering ops, credits, traps and counters
module csr_unit_tb import csr_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int              QUEUE_DEPTH = 2;
  localparam logic [XLEN-1:0] HART_ID     = 32'h0000_0003;
  localparam logic [XLEN-1:0] MTVEC_RESET = 32'h0000_4001;
  localparam int              RETIRE_K    = 7;
  // Budget: reset, about 40 accesses of 4 cycles, credit burst, retire pulses, x2 margin
  localparam int TIMEOUT_CYCLES = 2 * (16 + 40 * 4 + QUEUE_DEPTH + 8 + 2 * RETIRE_K);

  logic clk, rst_n;
  logic req_valid, credit, rsp_valid, retire, irq_enable;
  csr_req_t req;
  csr_rsp_t rsp;
  trap_ctrl_t trap;
  logic [XLEN-1:0] mip, mie_out, mepc_out;
  mtvec_t mtvec_out;

  logic [31:0]     lfsr_q = 32'hedc8_bd3e;
  int              requests_sent = 0;
  int              credits_back  = 0;
  int              cycle_count   = 0;
  logic [XLEN-1:0] scratch_m, mie_m, mepc_m, mtvec_m;  // Expected register contents

  tb_clock u_clock (.clk_o (clk), .rst_n_o (rst_n));

  csr_unit #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .HART_ID     (HART_ID),
    .MTVEC_RESET (MTVEC_RESET)
  ) uut (
    .clk (clk), .rst_n (rst_n),
    .req_valid_i (req_valid), .req_i (req),
    .credit_o (credit), .rsp_valid_o (rsp_valid), .rsp_o (rsp),
    .mip_i (mip), .trap_i (trap), .retire_i (retire),
    .mie_o (mie_out), .mtvec_o (mtvec_out), .mepc_o (mepc_out),
    .irq_enable_o (irq_enable)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_word(output logic [XLEN-1:0] w);
    for (int i = 0; i < XLEN; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w      = {w[XLEN-2:0], lfsr_q[0]};  // One step per bit
    end
  endtask

  // Expected stored value after a software write
  function automatic logic [XLEN-1:0] legalize(input csr_addr_e a, input logic [XLEN-1:0] v);
    case (a)
      CSR_MIE:   return v & IRQ_MASK;
      CSR_MEPC:  return {v[31:1], 1'b0};
      CSR_MTVEC: return {v[31:8], 7'd0, v[0]};
      default:   return v;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rsp(input csr_rsp_t got, input csr_rsp_t exp, input string what);
    if (got !== exp) abort_run($sformatf("mismatch at %0t: %s rdata %h illegal %b, expected %h %b",
                                         $time, what, got.rdata, got.illegal,
                                         exp.rdata, exp.illegal));
  endtask

  task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
    if (got !== exp) abort_run($sformatf("mismatch at %0t: %s is %h, expected %h",
                                         $time, what, got, exp));
  endtask

  task automatic check_mtvec(input mtvec_t got, input mtvec_t exp, input string what);
    if (got !== exp) abort_run($sformatf("mismatch at %0t: %s base %h mode %b, expected %h %b",
                                         $time, what, got.base, got.mode, exp.base, exp.mode));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) abort_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                                         $time, what, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Drive and sample off the edge
  endtask

  task automatic wait_credits(input int needed);
    int tries;
    tries = 0;
    while (QUEUE_DEPTH - requests_sent + credits_back < needed) begin
      next_cycle();
      tries++;
      if (tries > 16) abort_run("no credit came back to the sender");
    end
  endtask

  task automatic issue_req(input csr_op_e op, input logic [11:0] addr,
                           input logic [XLEN-1:0] wdata);
    wait_credits(1);
    req_valid = 1'b1;
    req.op    = op;
    req.addr  = csr_addr_e'(addr);
    req.wdata = wdata;
    requests_sent++;
    next_cycle();
    req_valid = 1'b0;
  endtask

  task automatic wait_rsp(output csr_rsp_t r);
    int tries;
    tries = 0;
    while (!rsp_valid) begin
      next_cycle();
      tries++;
      if (tries > 8) abort_run("no response came back for a request");
    end
    r = rsp;
  endtask

  task automatic access(input csr_op_e op, input logic [11:0] addr,
                        input logic [XLEN-1:0] wdata, output csr_rsp_t r);
    issue_req(op, addr, wdata);
    wait_rsp(r);
  endtask

  // Access and expect a legal response with the given old value
  task automatic expect_access(input csr_op_e op, input logic [11:0] addr,
                               input logic [XLEN-1:0] wdata, input logic [XLEN-1:0] old,
                               input string what);
    csr_rsp_t r;
    access(op, addr, wdata, r);
    check_rsp(r, '{rdata: old, illegal: 1'b0}, what);
  endtask

  // WRITE, SET, CLEAR then READ back
  task automatic exercise_reg(input csr_addr_e a, inout logic [XLEN-1:0] model);
    logic [XLEN-1:0] d;
    random_word(d);
    expect_access(CSR_OP_WRITE, a, d, model, {a.name(), " write"});
    model = legalize(a, d);
    random_word(d);
    expect_access(CSR_OP_SET, a, d, model, {a.name(), " set"});
    model = legalize(a, model | d);
    random_word(d);
    expect_access(CSR_OP_CLEAR, a, d, model, {a.name(), " clear"});
    model = legalize(a, model & ~d);
    expect_access(CSR_OP_READ, a, '0, model, {a.name(), " read back"});
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_reset();
    csr_rsp_t r;
    check_bit(credit, 1'b0, "credit after reset");
    check_bit(rsp_valid, 1'b0, "rsp_valid after reset");
    check_bit(irq_enable, 1'b0, "irq_enable after reset");
    check_mtvec(mtvec_out, mtvec_t'(MTVEC_RESET), "mtvec after reset");
    expect_access(CSR_OP_READ, CSR_MCOUNTINHIBIT, '0, MCOUNTINHIBIT_MASK, "mcountinhibit");
    expect_access(CSR_OP_READ, CSR_MISA, '0, MISA_VALUE, "misa");
    expect_access(CSR_OP_READ, CSR_MHARTID, '0, HART_ID, "mhartid");
    expect_access(CSR_OP_READ, CSR_MIP, '0, IRQ_MASK, "mip with all lines high");
    access(CSR_OP_READ, 12'h7C0, '0, r);
    check_rsp(r, '{rdata: '0, illegal: 1'b1}, "unknown address");
  endtask

  task automatic test_ops();
    exercise_reg(CSR_MSCRATCH, scratch_m);
    exercise_reg(CSR_MIE, mie_m);
    exercise_reg(CSR_MEPC, mepc_m);
    exercise_reg(CSR_MTVEC, mtvec_m);
    check_word(mie_out, mie_m, "mie_o");
    check_word(mepc_out, mepc_m, "mepc_o");
    check_mtvec(mtvec_out, mtvec_t'(mtvec_m), "mtvec_o");
  endtask

  task automatic test_credits();
    logic [XLEN-1:0] vals [QUEUE_DEPTH];
    logic [XLEN-1:0] olds [QUEUE_DEPTH];
    int pulses, got;
    // Empty queue, answer in the cycle after edge N+1
    wait_credits(QUEUE_DEPTH);
    issue_req(CSR_OP_READ, CSR_MISA, '0);
    check_bit(rsp_valid, 1'b0, "rsp_valid one cycle after request");
    next_cycle();
    check_bit(rsp_valid, 1'b1, "rsp_valid two cycles after request");
    check_bit(credit, 1'b1, "credit with response");
    check_rsp(rsp, '{rdata: MISA_VALUE, illegal: 1'b0}, "misa on empty queue");
    // Back-to-back burst of mscratch writes, each returns the previous value
    wait_credits(QUEUE_DEPTH);
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      random_word(vals[i]);
      olds[i] = (i == 0) ? scratch_m : vals[i-1];
    end
    pulses = 0;
    got    = 0;
    for (int c = 0; c < QUEUE_DEPTH + 4; c++) begin
      check_bit(credit, rsp_valid, "credit against rsp_valid");
      if (credit) pulses++;
      if (rsp_valid) begin
        if (got != c - 2) abort_run("burst response out of order or late");
        check_rsp(rsp, '{rdata: olds[got], illegal: 1'b0}, "burst response");
        got++;
      end
      req_valid = (c < QUEUE_DEPTH);
      if (c < QUEUE_DEPTH) begin
        req.op    = CSR_OP_WRITE;
        req.addr  = CSR_MSCRATCH;
        req.wdata = vals[c];
        requests_sent++;
      end
      next_cycle();
    end
    if (pulses != QUEUE_DEPTH) abort_run("wrong number of credit pulses for the burst");
    scratch_m = vals[QUEUE_DEPTH-1];
  endtask

  task automatic test_trap();
    csr_rsp_t r;
    expect_access(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0008, '0, "mstatus set mie");
    check_bit(irq_enable, 1'b1, "irq_enable with mstatus.mie");
    issue_req(CSR_OP_WRITE, CSR_MEPC, 32'h0000_9990);
    trap.save_cause = 1'b1;           // Same edge as the mepc write
    trap.cause      = 6'b1_00111;     // Machine timer interrupt
    trap.pc         = 32'h0000_2468;
    next_cycle();
    trap = '0;
    wait_rsp(r);
    check_rsp(r, '{rdata: mepc_m, illegal: 1'b0}, "mepc write during trap");
    check_word(mepc_out, 32'h0000_2468, "mepc_o after trap");
    check_bit(irq_enable, 1'b0, "irq_enable after trap");
    expect_access(CSR_OP_READ, CSR_MCAUSE, '0, 32'h8000_0007, "mcause after trap");
    expect_access(CSR_OP_READ, CSR_MSTATUS, '0, 32'h0000_0080, "mstatus after trap");
    trap.restore_mret = 1'b1;
    next_cycle();
    trap = '0;
    check_bit(irq_enable, 1'b1, "irq_enable after mret");
    expect_access(CSR_OP_READ, CSR_MSTATUS, '0, 32'h0000_0088, "mstatus after mret");
  endtask

  task automatic test_counters();
    csr_rsp_t        r;
    logic [XLEN-1:0] d, first;
    expect_access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, '0, MCOUNTINHIBIT_MASK, "uninhibit");
    repeat (RETIRE_K) begin
      retire = 1'b1;
      next_cycle();
      retire = 1'b0;
      next_cycle();
    end
    expect_access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, MCOUNTINHIBIT_MASK, '0, "inhibit again");
    expect_access(CSR_OP_READ, CSR_MINSTRET, '0, RETIRE_K, "minstret after retires");
    random_word(d);
    expect_access(CSR_OP_WRITE, CSR_MCYCLEH, d, '0, "mcycleh write");
    expect_access(CSR_OP_READ, CSR_MCYCLEH, '0, d, "mcycleh read back");
    // Free-run mcycle only
    expect_access(CSR_OP_CLEAR, CSR_MCOUNTINHIBIT, 32'd1, MCOUNTINHIBIT_MASK, "run mcycle");
    access(CSR_OP_READ, CSR_MCYCLE, '0, r);
    first = r.rdata;
    access(CSR_OP_READ, CSR_MCYCLE, '0, r);
    check_bit(r.rdata > first, 1'b1, "mcycle increasing");
  endtask

  ////////////////////////////////////////
  // Credit count, timeout, sequence
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (credit) credits_back++;
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) abort_run("timeout, the run went past its cycle budget");
  end

  initial begin
    req_valid = 1'b0;
    req       = '0;
    mip       = '1;
    trap      = '0;
    retire    = 1'b0;
    scratch_m = '0;
    mie_m     = '0;
    mepc_m    = '0;
    mtvec_m   = MTVEC_RESET;
    @(posedge rst_n);
    next_cycle();
    test_reset();
    test_ops();
    test_credits();
    test_trap();
    test_counters();
    if (uut.u_chk.fail_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("%0d assertion failures in the bound checker", uut.u_chk.fail_count);
      $display("Some tests failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// ==== tb/tb_clock.sv ====
// Testbench clock and reset generator, 8 ns period with a 16-cycle reset
module tb_clock #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;  // Released off the edge
  end

endmodule

// ==== verilog/csr_access.sv ====
// CSR access logic: decode head request, read old value, drive write strobe, respond
module csr_access import csr_pkg::*; #(
  parameter logic [XLEN-1:0] HART_ID = '0
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            head_valid_i,
  input  csr_req_t        head_i,
  input  logic [XLEN-1:0] mip_i,
  input  trap_vals_t      trap_vals_i,
  input  cnt_vals_t       cnt_vals_i,
  output logic            pop_o,
  output csr_wr_t         wr_o,
  output logic            rsp_valid_o,
  output csr_rsp_t        rsp_o
);

  logic [XLEN-1:0] old_val;   // Read mux result
  logic [XLEN-1:0] new_val;   // Value after op
  logic            illegal;
  logic            do_write;
  logic            rsp_valid_q;
  csr_rsp_t        rsp_q;

  assign pop_o = head_valid_i;  // Single-cycle access, always accept

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////

  always_comb begin
    old_val = '0;
    illegal = 1'b0;
    case (head_i.addr)
      CSR_MSTATUS:       old_val = trap_vals_i.mstatus;
      CSR_MISA:          old_val = MISA_VALUE;
      CSR_MIE:           old_val = trap_vals_i.mie;
      CSR_MTVEC:         old_val = trap_vals_i.mtvec;
      CSR_MCOUNTINHIBIT: old_val = cnt_vals_i.mcountinhibit;
      CSR_MSCRATCH:      old_val = trap_vals_i.mscratch;
      CSR_MEPC:          old_val = trap_vals_i.mepc;
      CSR_MCAUSE:        old_val = trap_vals_i.mcause;
      CSR_MIP:           old_val = mip_i & IRQ_MASK;  // Only implemented lines
      CSR_MCYCLE:        old_val = cnt_vals_i.mcycle[XLEN-1:0];
      CSR_MCYCLEH:       old_val = cnt_vals_i.mcycle[2*XLEN-1:XLEN];
      CSR_MINSTRET:      old_val = cnt_vals_i.minstret[XLEN-1:0];
      CSR_MINSTRETH:     old_val = cnt_vals_i.minstret[2*XLEN-1:XLEN];
      CSR_MHARTID:       old_val = HART_ID;
      default:           illegal = 1'b1;  // Reads zero
    endcase
  end

  ////////////////////////////////////////
  // Op and write strobe
  ////////////////////////////////////////

  always_comb begin
    new_val  = head_i.wdata;
    do_write = 1'b1;
    case (head_i.op)
      CSR_OP_WRITE: new_val = head_i.wdata;
      CSR_OP_SET:   new_val = old_val | head_i.wdata;
      CSR_OP_CLEAR: new_val = old_val & ~head_i.wdata;
      default:      do_write = 1'b0;  // READ
    endcase
  end

  // Legalizing is left to the register blocks
  always_comb begin
    wr_o      = '0;
    wr_o.data = new_val;
    if (head_valid_i && do_write) begin
      case (head_i.addr)
        CSR_MSTATUS:       wr_o.mstatus       = 1'b1;
        CSR_MIE:           wr_o.mie           = 1'b1;
        CSR_MTVEC:         wr_o.mtvec         = 1'b1;
        CSR_MSCRATCH:      wr_o.mscratch      = 1'b1;
        CSR_MEPC:          wr_o.mepc          = 1'b1;
        CSR_MCAUSE:        wr_o.mcause        = 1'b1;
        CSR_MCOUNTINHIBIT: wr_o.mcountinhibit = 1'b1;
        CSR_MCYCLE:        wr_o.mcycle        = 1'b1;
        CSR_MCYCLEH:       wr_o.mcycleh       = 1'b1;
        CSR_MINSTRET:      wr_o.minstret      = 1'b1;
        CSR_MINSTRETH:     wr_o.minstreth     = 1'b1;
        default: ;  // misa, mip, mhartid and unknown are read-only
      endcase
    end
  end

  ////////////////////////////////////////
  // Response register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= pop_o;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      rsp_q.rdata   <= old_val;  // Old value, as the ISA requires
      rsp_q.illegal <= illegal;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// ==== verilog/csr_perf_counters.sv ====
// mcycle and minstret counters with mcountinhibit and split 32-bit writes
module csr_perf_counters import csr_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  csr_wr_t   wr_i,
  input  logic      retire_i,   // One instruction retired this cycle
  output cnt_vals_t cnt_vals_o
);

  logic [XLEN-1:0]   mcountinhibit_q;
  logic [2*XLEN-1:0] mcycle_q;
  logic [2*XLEN-1:0] minstret_q;
  logic              cycle_inc;
  logic              instret_inc;

  // Next counter value, a half write wins over the increment
  function automatic logic [2*XLEN-1:0] cnt_next(
    input logic [2*XLEN-1:0] cnt,
    input logic              wr_lo,
    input logic              wr_hi,
    input logic              inc,
    input logic [XLEN-1:0]   data
  );
    logic [2*XLEN-1:0] nxt;
    nxt = cnt;
    if (wr_lo) begin
      nxt[XLEN-1:0] = data;
    end else if (wr_hi) begin
      nxt[2*XLEN-1:XLEN] = data;
    end else if (inc) begin
      nxt = cnt + 1'b1;
    end
    return nxt;
  endfunction

  assign cycle_inc   = ~mcountinhibit_q[INHIBIT_CY_BIT];
  assign instret_inc = ~mcountinhibit_q[INHIBIT_IR_BIT] & retire_i;

  ////////////////////////////////////////
  // Inhibit and counters
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcountinhibit_q <= MCOUNTINHIBIT_MASK;  // Stopped out of reset
    end else if (wr_i.mcountinhibit) begin
      mcountinhibit_q <= wr_i.data & MCOUNTINHIBIT_MASK;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mcycle_q   <= cnt_next(mcycle_q, wr_i.mcycle, wr_i.mcycleh, cycle_inc, wr_i.data);
      minstret_q <= cnt_next(minstret_q, wr_i.minstret, wr_i.minstreth, instret_inc,
                             wr_i.data);
    end
  end

  assign cnt_vals_o = '{
    mcountinhibit: mcountinhibit_q,
    mcycle:        mcycle_q,
    minstret:      minstret_q
  };

endmodule

// ==== verilog/csr_pkg.sv ====
// CSR package with opcodes, CSR numbers, structs and machine-mode constants
package csr_pkg;

  localparam int XLEN = 32;

  ////////////////////////////////////////
  // Architectural constants
  ////////////////////////////////////////

  localparam logic [XLEN-1:0] MISA_VALUE         = 32'h4000_1104; // MXL=1, I, M, C
  localparam logic [XLEN-1:0] IRQ_MASK           = 32'hFFFF_0888; // Fast 16..31, MEIE, MTIE, MSIE
  localparam logic [XLEN-1:0] MCOUNTINHIBIT_MASK = 32'h0000_0005; // CY and IR only

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int INHIBIT_CY_BIT   = 0;  // mcycle
  localparam int INHIBIT_IR_BIT   = 2;  // minstret

  ////////////////////////////////////////
  // Opcodes and CSR numbers
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82,
    CSR_MHARTID       = 12'hF14
  } csr_addr_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  typedef struct packed {
    csr_op_e         op;
    csr_addr_e       addr;
    logic [XLEN-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;   // Old value of the CSR
    logic            illegal; // Unknown address
  } csr_rsp_t;

  typedef struct packed {
    logic [31:8] zero2;
    logic        mpie;
    logic [6:4]  zero1;
    logic        mie;
    logic [2:0]  zero0;
  } mstatus_t;

  typedef struct packed {
    logic [31:8] base;
    logic [7:2]  zero;
    logic [1:0]  mode;  // Only bit 0 writable
  } mtvec_t;

  typedef struct packed {
    logic            save_cause;
    logic            restore_mret;
    logic [5:0]      cause;  // Interrupt flag in bit 5, code below
    logic [XLEN-1:0] pc;
  } trap_ctrl_t;

  // One-hot software write strobe plus data
  typedef struct packed {
    logic            mstatus;
    logic            mie;
    logic            mtvec;
    logic            mscratch;
    logic            mepc;
    logic            mcause;
    logic            mcountinhibit;
    logic            mcycle;
    logic            mcycleh;
    logic            minstret;
    logic            minstreth;
    logic [XLEN-1:0] data;
  } csr_wr_t;

  typedef struct packed {
    mstatus_t        mstatus;
    logic [XLEN-1:0] mie;
    mtvec_t          mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
  } trap_vals_t;

  typedef struct packed {
    logic [XLEN-1:0]   mcountinhibit;
    logic [2*XLEN-1:0] mcycle;
    logic [2*XLEN-1:0] minstret;
  } cnt_vals_t;

endpackage

// ==== verilog/csr_req_queue.sv ====
// Request queue, a circular FIFO returning one credit per released entry
module csr_req_queue import csr_pkg::*; #(
  parameter int QUEUE_DEPTH = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push_i,        // Only while the sender holds a credit
  input  csr_req_t req_i,
  output logic     head_valid_o,
  output csr_req_t head_o,
  output logic     credit_o,      // One pulse per pop
  input  logic     pop_i
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  csr_req_t         mem_q [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;    // Entries held
  logic             credit_q;
  logic             pop;

  // Wrap at depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign pop = pop_i & head_valid_o;  // Ignore a pop on empty

  // Storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

  // Pointers, fill level and credit return
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q  <= count_q + CNT_W'(push_i) - CNT_W'(pop);
      credit_q <= pop;  // Lines up with the registered response
    end
  end

  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];
  assign credit_o     = credit_q;

endmodule

// ==== verilog/csr_trap_regs.sv ====
// Machine trap registers with trap entry and mret taking priority over software
module csr_trap_regs import csr_pkg::*; #(
  parameter logic [XLEN-1:0] MTVEC_RESET = '0
) (
  input  logic            clk,
  input  logic            rst_n,
  input  csr_wr_t         wr_i,
  input  trap_ctrl_t      trap_i,
  output trap_vals_t      trap_vals_o,
  output logic [XLEN-1:0] mie_o,
  output mtvec_t          mtvec_o,
  output logic [XLEN-1:0] mepc_o,
  output logic            irq_enable_o
);

  mstatus_t        mstatus_q;
  logic [XLEN-1:0] mie_q;
  mtvec_t          mtvec_q;
  logic [XLEN-1:0] mscratch_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;

  mstatus_t        mstatus_wr;  // Legalized software values
  mtvec_t          mtvec_wr;

  always_comb begin
    mstatus_wr      = '0;
    mstatus_wr.mie  = wr_i.data[MSTATUS_MIE_BIT];
    mstatus_wr.mpie = wr_i.data[MSTATUS_MPIE_BIT];
    mtvec_wr        = '0;
    mtvec_wr.base   = wr_i.data[31:8];
    mtvec_wr.mode   = {1'b0, wr_i.data[0]};  // Direct or vectored
  end

  ////////////////////////////////////////
  // Trap state
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (trap_i.save_cause) begin
      mstatus_q.mpie <= mstatus_q.mie;  // Stack interrupt enable
      mstatus_q.mie  <= 1'b0;
      mepc_q         <= trap_i.pc;
      mcause_q       <= {trap_i.cause[5], 26'd0, trap_i.cause[4:0]};
    end else if (trap_i.restore_mret) begin
      mstatus_q.mie  <= mstatus_q.mpie; // Unstack
      mstatus_q.mpie <= 1'b1;
    end else begin
      if (wr_i.mstatus) mstatus_q <= mstatus_wr;
      if (wr_i.mepc) mepc_q <= wr_i.data & ~32'd1;  // Halfword aligned
      if (wr_i.mcause) mcause_q <= {wr_i.data[31], 26'd0, wr_i.data[4:0]};
    end
  end

  ////////////////////////////////////////
  // Software-only registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q      <= '0;
      mtvec_q    <= mtvec_t'(MTVEC_RESET);
      mscratch_q <= '0;
    end else begin
      if (wr_i.mie) mie_q <= wr_i.data & IRQ_MASK;
      if (wr_i.mtvec) mtvec_q <= mtvec_wr;
      if (wr_i.mscratch) mscratch_q <= wr_i.data;
    end
  end

  // Values for the read mux
  assign trap_vals_o = '{
    mstatus:  mstatus_q,
    mie:      mie_q,
    mtvec:    mtvec_q,
    mscratch: mscratch_q,
    mepc:     mepc_q,
    mcause:   mcause_q
  };

  assign mie_o        = mie_q;
  assign mtvec_o      = mtvec_q;
  assign mepc_o       = mepc_q;
  assign irq_enable_o = mstatus_q.mie;  // Global enable straight from mstatus

endmodule

// ==== verilog/csr_unit.sv ====
// Machine-mode CSR unit with a credit-based request port and trap interface
module csr_unit import csr_pkg::*; #(
  parameter int              QUEUE_DEPTH = 2,
  parameter logic [XLEN-1:0] HART_ID     = '0,
  parameter logic [XLEN-1:0] MTVEC_RESET = 32'h0000_1001  // Base 0x1000, vectored
) (
  input  logic            clk,
  input  logic            rst_n,
  // Request and response
  input  logic            req_valid_i,
  input  csr_req_t        req_i,
  output logic            credit_o,
  output logic            rsp_valid_o,
  output csr_rsp_t        rsp_o,
  // Core side
  input  logic [XLEN-1:0] mip_i,
  input  trap_ctrl_t      trap_i,
  input  logic            retire_i,
  output logic [XLEN-1:0] mie_o,
  output mtvec_t          mtvec_o,
  output logic [XLEN-1:0] mepc_o,
  output logic            irq_enable_o
);

  logic       head_valid;
  csr_req_t   head;
  logic       pop;
  csr_wr_t    wr;         // Shared write strobe
  trap_vals_t trap_vals;
  cnt_vals_t  cnt_vals;

  csr_req_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (req_valid_i),
    .req_i        (req_i),
    .head_valid_o (head_valid),
    .head_o       (head),
    .credit_o     (credit_o),
    .pop_i        (pop)
  );

  csr_access #(
    .HART_ID (HART_ID)
  ) u_access (
    .clk          (clk),
    .rst_n        (rst_n),
    .head_valid_i (head_valid),
    .head_i       (head),
    .mip_i        (mip_i),
    .trap_vals_i  (trap_vals),
    .cnt_vals_i   (cnt_vals),
    .pop_o        (pop),
    .wr_o         (wr),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

  csr_trap_regs #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_trap_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_i         (wr),
    .trap_i       (trap_i),
    .trap_vals_o  (trap_vals),
    .mie_o        (mie_o),
    .mtvec_o      (mtvec_o),
    .mepc_o       (mepc_o),
    .irq_enable_o (irq_enable_o)
  );

  csr_perf_counters u_counters (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_i       (wr),
    .retire_i   (retire_i),
    .cnt_vals_o (cnt_vals)
  );

endmodule
